//--- Makefile
TOP = tb_tx_path

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; \
	cat sim.log; \
	! grep -q "Something failed" sim.log && test $$status -eq 0

clean:
	rm -rf obj_dir sim.log

//--- rtl/tx_data_fifo.sv
// Synchronous first-word-fall-through FIFO for transmit beats
// Each entry holds 64 data bits, a strobe code and an end flag
// Writes when full and reads when empty are dropped silently
// empty and almost_full are registered, a write shows up one cycle later
`timescale 1ns/10ps
`default_nettype none
`include "tx_path_params.svh"

module tx_data_fifo (
   input  logic       clk,
   input  logic       reset,
   tx_fifo_if.fifo_mp fifo
);
   import tx_path_pkg::*;

   localparam int AW    = `TX_FIFO_ADDR_W;
   localparam int DEPTH = 1 << AW;

   localparam logic [AW:0]   FULL_LEVEL  = (AW+1)'(DEPTH);
   localparam logic [AW:0]   AFULL_LEVEL = (AW+1)'(DEPTH - `TX_AFULL_MARGIN);
   localparam logic [AW:0]   LEVEL_ONE   = (AW+1)'(1);
   localparam logic [AW-1:0] PTR_ONE     = AW'(1);

   // Storage, no reset needed
   logic [63:0] data_mem [DEPTH];
   strb_code_t  code_mem [DEPTH];
   logic        last_mem [DEPTH];

   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   level;
   logic [AW:0]   level_next;
   logic          do_wr;
   logic          do_rd;

   assign do_wr = fifo.wr_en && (level != FULL_LEVEL);
   assign do_rd = fifo.rd_en && !fifo.empty;

   always_comb begin
      case ({do_wr, do_rd})
         2'b10:   level_next = level + LEVEL_ONE;
         2'b01:   level_next = level - LEVEL_ONE;
         default: level_next = level;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // Pointers and flags
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr           <= '0;
         rd_ptr           <= '0;
         level            <= '0;
         fifo.empty       <= 1'b1;
         fifo.almost_full <= 1'b0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + PTR_ONE;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + PTR_ONE;
         end
         level            <= level_next;
         fifo.empty       <= (level_next == '0);
         // Free space at or below the margin
         fifo.almost_full <= (level_next >= AFULL_LEVEL);
      end
   end

   always_ff @(posedge clk) begin
      if (do_wr) begin
         data_mem[wr_ptr] <= fifo.wr_data;
         code_mem[wr_ptr] <= fifo.wr_code;
         last_mem[wr_ptr] <= fifo.wr_last;
      end
   end

   // Head entry falls through without a read request
   assign fifo.rd_data = data_mem[rd_ptr];
   assign fifo.rd_code = code_mem[rd_ptr];
   assign fifo.rd_last = last_mem[rd_ptr];
   assign fifo.level   = level;

endmodule

`default_nettype wire

//--- rtl/tx_fifo_if.sv
// Bundle between the transmit queue and its beat FIFO
// Read side is first-word-fall-through, head valid while empty is low
`timescale 1ns/10ps
`default_nettype none
`include "tx_path_params.svh"

interface tx_fifo_if;
   import tx_path_pkg::*;

   // Write side
   logic [63:0]              wr_data;
   strb_code_t               wr_code;
   logic                     wr_last;
   logic                     wr_en;
   logic                     almost_full;
   // Current fill, mostly for monitoring
   logic [`TX_FIFO_ADDR_W:0] level;

   // Read side
   logic [63:0]              rd_data;
   strb_code_t               rd_code;
   logic                     rd_last;
   logic                     empty;
   logic                     rd_en;

   modport wr_mp (output wr_data, wr_code, wr_last, wr_en, input almost_full, level);
   modport rd_mp (input rd_data, rd_code, rd_last, empty, output rd_en);
   modport fifo_mp (
      input  wr_data, wr_code, wr_last, wr_en, rd_en,
      output almost_full, level, rd_data, rd_code, rd_last, empty
   );

endinterface

`default_nettype wire

//--- rtl/tx_path_params.svh
// Sizing of the transmit path FIFO and the packet counter
// Depth is a power of two set by its address width
// A packet longer than depth minus margin deadlocks the queue
`ifndef TX_PATH_PARAMS_SVH
`define TX_PATH_PARAMS_SVH

// log2 of the beat FIFO depth
`define TX_FIFO_ADDR_W 9

// Free entries at or below which almost_full is raised
`define TX_AFULL_MARGIN 10

// One bit wider than the FIFO address, counts up to depth packets
`define TX_PKT_CNT_W (`TX_FIFO_ADDR_W + 1)

`endif

//--- rtl/tx_path_pkg.sv
// Types shared by the transmit path blocks
// Strobe codes 0..7 mean bytes 0..n valid, 8 marks an illegal strobe
`default_nettype none

package tx_path_pkg;

   // MAC-side send sequence
   typedef enum logic [1:0] {
      IDLE,
      WAIT_ACK,
      SEND,
      IFG
   } tx_state_t;

   // Compressed byte strobe stored alongside each beat
   typedef logic [3:0] strb_code_t;

   // Anything that is not a low-aligned contiguous strobe
   localparam strb_code_t STRB_ILLEGAL = 4'h8;

endpackage

`default_nettype wire

//--- rtl/tx_path_top.sv
// Transmit path top, AXI-stream in and 10G MAC framing out
// Everything runs on clk, data width fixed at 64 bits
`timescale 1ns/10ps
`default_nettype none

module tx_path_top (
   input  logic        clk,
   input  logic        reset,
   // AXI-stream slave
   input  logic [63:0] tdata,
   input  logic [7:0]  tstrb,
   input  logic        tvalid,
   input  logic        tlast,
   output logic        tready,
   // MAC transmit side
   output logic [63:0] tx_data,
   output logic [7:0]  tx_data_valid,
   output logic        tx_start,
   input  logic        tx_ack
);

   tx_fifo_if fifo_bus ();

   tx_queue u_queue (
      .clk           (clk),
      .reset         (reset),
      .tdata         (tdata),
      .tstrb         (tstrb),
      .tvalid        (tvalid),
      .tlast         (tlast),
      .tready        (tready),
      .tx_data       (tx_data),
      .tx_data_valid (tx_data_valid),
      .tx_start      (tx_start),
      .tx_ack        (tx_ack),
      .wr            (fifo_bus.wr_mp),
      .rd            (fifo_bus.rd_mp)
   );

   tx_data_fifo u_fifo (
      .clk   (clk),
      .reset (reset),
      .fifo  (fifo_bus.fifo_mp)
   );

endmodule

`default_nettype wire

//--- rtl/tx_queue.sv
// AXI-stream to 10G MAC transmit converter, single clock
// Store and forward, a packet is sent only once fully queued
// Only low-aligned contiguous strobes survive, others give zero byte-valid
// The MAC cannot stall a packet after tx_ack
`timescale 1ns/10ps
`default_nettype none
`include "tx_path_params.svh"

module tx_queue (
   input  logic        clk,
   input  logic        reset,
   // AXI-stream slave
   input  logic [63:0] tdata,
   input  logic [7:0]  tstrb,
   input  logic        tvalid,
   input  logic        tlast,
   output logic        tready,
   // MAC transmit side
   output logic [63:0] tx_data,
   output logic [7:0]  tx_data_valid,
   output logic        tx_start,
   input  logic        tx_ack,
   // Beat FIFO
   tx_fifo_if.wr_mp    wr,
   tx_fifo_if.rd_mp    rd
);
   import tx_path_pkg::*;

   localparam logic [`TX_PKT_CNT_W-1:0] CNT_ONE = `TX_PKT_CNT_W'(1);

   tx_state_t                state;
   logic [`TX_PKT_CNT_W-1:0] pkt_cnt;
   logic                     beat_accept;
   logic                     pkt_done;
   logic                     out_load;
   logic [63:0]              out_data;
   strb_code_t               out_code;
   logic                     out_last;

   // Byte strobe to 4-bit code
   function automatic strb_code_t encode_strb(input logic [7:0] strb);
      case (strb)
         8'h01:   return 4'h0;
         8'h03:   return 4'h1;
         8'h07:   return 4'h2;
         8'h0F:   return 4'h3;
         8'h1F:   return 4'h4;
         8'h3F:   return 4'h5;
         8'h7F:   return 4'h6;
         8'hFF:   return 4'h7;
         default: return STRB_ILLEGAL;
      endcase
   endfunction

   // Code n gives bytes 0..n, anything above 7 gives nothing
   function automatic logic [7:0] decode_strb(input strb_code_t code);
      if (code >= STRB_ILLEGAL) begin
         return 8'h00;
      end
      return 8'hFF >> (3'd7 - code[2:0]);
   endfunction

   //////////////////////////////////////////////////////////////////////
   // AXI write side
   //////////////////////////////////////////////////////////////////////

   assign tready      = ~wr.almost_full;
   assign beat_accept = tvalid & tready;

   assign wr.wr_en   = beat_accept;
   assign wr.wr_data = tdata;
   assign wr.wr_code = encode_strb(tstrb);
   assign wr.wr_last = tlast;

   // Delayed so the counter never runs ahead of the FIFO contents
   always_ff @(posedge clk) begin
      if (reset) begin
         pkt_done <= 1'b0;
      end else begin
         pkt_done <= beat_accept & tlast;
      end
   end

   // Complete packets waiting in the FIFO
   always_ff @(posedge clk) begin
      if (reset) begin
         pkt_cnt <= '0;
      end else begin
         case ({pkt_done, tx_start})
            2'b10:   pkt_cnt <= pkt_cnt + CNT_ONE;
            2'b01:   pkt_cnt <= pkt_cnt - CNT_ONE;
            default: pkt_cnt <= pkt_cnt;
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // MAC read side
   //////////////////////////////////////////////////////////////////////

   assign tx_start = (state == IDLE) && (pkt_cnt != '0);

   // Pop on ack, then once per SEND cycle until the end beat is out
   assign out_load = ((state == WAIT_ACK) && tx_ack) || ((state == SEND) && !out_last);
   assign rd.rd_en = out_load;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= IDLE;
      end else begin
         case (state)
            IDLE: begin
               if (pkt_cnt != '0) begin
                  state <= WAIT_ACK;
               end
            end
            WAIT_ACK: begin
               if (tx_ack) begin
                  state <= SEND;
               end
            end
            SEND: begin
               if (out_last) begin
                  state <= IFG;
               end
            end
            // One idle beat between frames
            IFG: state <= IDLE;
            default: state <= IDLE;
         endcase
      end
   end

   // Output beat register
   always_ff @(posedge clk) begin
      if (out_load) begin
         out_data <= rd.rd_data;
         out_code <= rd.rd_code;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         out_last <= 1'b0;
      end else if (out_load) begin
         out_last <= rd.rd_last;
      end
   end

   assign tx_data       = out_data;
   assign tx_data_valid = (state == SEND) ? decode_strb(out_code) : 8'h00;

endmodule

`default_nettype wire

//--- sim.f
+incdir+rtl
rtl/tx_path_pkg.sv
rtl/tx_fifo_if.sv
rtl/tx_data_fifo.sv
rtl/tx_queue.sv
rtl/tx_path_top.sv
test/tx_path_sva.sv
test/tb_tx_path.sv

//--- test/tb_tx_path.sv
// Testbench for the transmit path, AXI-stream in and MAC framing out
// The MAC is modelled here, acking after a random delay of 0 to 40 cycles
// Inputs change on the falling edge, outputs are sampled on the falling edge
// Packet length is kept at or below FIFO depth minus margin minus 2
`timescale 1ns/10ps
`default_nettype none
`include "tx_path_params.svh"

module tb_tx_path;

   localparam int DEPTH       = 1 << `TX_FIFO_ADDR_W;
   localparam int MAX_LEN     = DEPTH - `TX_AFULL_MARGIN - 2;
   localparam int BEAT_LIMIT  = 2000;
   localparam int DRAIN_LIMIT = 5000;

   logic        clk;
   logic        reset;
   logic [63:0] tdata;
   logic [7:0]  tstrb;
   logic        tvalid;
   logic        tlast;
   logic        tready;
   logic [63:0] tx_data;
   logic [7:0]  tx_data_valid;
   logic        tx_start;
   logic        tx_ack;

   // Expected beats as {last, valid, data}
   logic [72:0] exp_q[$];
   logic [72:0] head_beat;
   logic [31:0] rng;
   int          errors;
   int          checks;
   int          tests_failed;
   int          pkts_in;
   int          starts;
   int          mac_phase;
   int          ack_wait;
   int          tready_low_cycles;
   logic        stall_mac;

   tx_path_top UUT (
      .clk           (clk),
      .reset         (reset),
      .tdata         (tdata),
      .tstrb         (tstrb),
      .tvalid        (tvalid),
      .tlast         (tlast),
      .tready        (tready),
      .tx_data       (tx_data),
      .tx_data_valid (tx_data_valid),
      .tx_start      (tx_start),
      .tx_ack        (tx_ack)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // xorshift32
   function logic [31:0] next_rand();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   // True when the set bytes start at byte 0 and have no holes
   function automatic logic low_contiguous(input logic [7:0] s);
      logic [7:0] plus_one;
      plus_one = s + 8'd1;
      return (s != 8'h00) && ((plus_one & s) == 8'h00);
   endfunction

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] want);
      checks++;
      if (got !== want) begin
         errors++;
         $display("Fail %s: got 0x%h, expected 0x%h at %0t", name, got, want, $time);
      end
   endtask

   task automatic abort_on_timeout(input string what);
      $display("Timeout while waiting for %s at %0t", what, $time);
      $display("Something failed");
      $finish;
   endtask

   task automatic finish_test(input string name, input int errors_before);
      if (errors == errors_before) begin
         $display("Test %s passed", name);
      end else begin
         tests_failed++;
         $display("Test %s failed with %0d errors", name, errors - errors_before);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // AXI driver
   //////////////////////////////////////////////////////////////////////

   task automatic send_packet(input int len);
      logic [31:0] r;
      logic [7:0]  valid_exp;
      int          cycles;
      for (int i = 0; i < len; i++) begin
         if ((next_rand() % 6) == 0) begin
            tvalid = 1'b0;
            @(negedge clk);
         end
         tdata = {next_rand(), next_rand()};
         tlast = (i == len - 1);
         tstrb = 8'hFF;
         // Tail strobe, about one in eight is illegal
         if (i == len - 1) begin
            r = next_rand();
            if (r[31:29] == 3'd0) begin
               tstrb = (r[7:0] & 8'hFE) | 8'h02;
            end else begin
               tstrb = 8'hFF >> r[2:0];
            end
         end
         tvalid = 1'b1;
         cycles = 0;
         while (!tready) begin
            @(negedge clk);
            cycles++;
            if (cycles > BEAT_LIMIT) abort_on_timeout("tready during a packet");
         end
         // tready holds until the next rising edge, so this beat is taken there
         valid_exp = low_contiguous(tstrb) ? tstrb : 8'h00;
         exp_q.push_back({tlast, valid_exp, tdata});
         if (tlast) pkts_in++;
         @(negedge clk);
      end
      tvalid = 1'b0;
      tlast  = 1'b0;
   endtask

   task automatic wait_drained();
      int cycles;
      cycles = 0;
      while (exp_q.size() != 0 || mac_phase != 0 || starts != pkts_in) begin
         @(negedge clk);
         cycles++;
         if (cycles > DRAIN_LIMIT) abort_on_timeout("the MAC side to drain");
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // MAC responder and checker
   //////////////////////////////////////////////////////////////////////

   always @(negedge clk) begin
      tx_ack = 1'b0;
      if (reset) begin
         mac_phase = 0;
      end else begin
         if (!tready) tready_low_cycles++;
         case (mac_phase)
            0: begin
               check_value("tx_data_valid", 64'(tx_data_valid), 64'h0);
               if (tx_start) begin
                  starts++;
                  if (starts > pkts_in) begin
                     errors++;
                     $display("tx_start pulsed with no complete packet queued at %0t", $time);
                  end
                  ack_wait  = int'(next_rand() % 41);
                  mac_phase = 1;
               end
            end
            1: begin
               // Start must be a single cycle pulse
               check_value("tx_start", 64'(tx_start), 64'h0);
               check_value("tx_data_valid", 64'(tx_data_valid), 64'h0);
               if (!stall_mac) begin
                  if (ack_wait == 0) begin
                     tx_ack    = 1'b1;
                     mac_phase = 2;
                  end else begin
                     ack_wait--;
                  end
               end
            end
            2: begin
               check_value("tx_start", 64'(tx_start), 64'h0);
               if (exp_q.size() == 0) begin
                  errors++;
                  $display("A beat reached the MAC with nothing expected at %0t", $time);
                  mac_phase = 3;
               end else begin
                  head_beat = exp_q.pop_front();
                  check_value("tx_data", tx_data, head_beat[63:0]);
                  check_value("tx_data_valid", 64'(tx_data_valid), 64'(head_beat[71:64]));
                  if (head_beat[72]) mac_phase = 3;
               end
            end
            default: begin
               // Inter-frame gap
               check_value("tx_start", 64'(tx_start), 64'h0);
               check_value("tx_data_valid", 64'(tx_data_valid), 64'h0);
               mac_phase = 0;
            end
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      int err_mark;
      int low_mark;
      int cycles;
      rng = 32'd58421;
      errors = 0;
      checks = 0;
      tests_failed = 0;
      pkts_in = 0;
      starts = 0;
      mac_phase = 0;
      ack_wait = 0;
      tready_low_cycles = 0;
      stall_mac = 1'b0;
      reset = 1'b1;
      tdata = 64'h0;
      tstrb = 8'h00;
      tvalid = 1'b0;
      tlast = 1'b0;
      tx_ack = 1'b0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      err_mark = errors;
      repeat (20) begin
         @(negedge clk);
         check_value("tready", 64'(tready), 64'h1);
         check_value("tx_start", 64'(tx_start), 64'h0);
         check_value("tx_data_valid", 64'(tx_data_valid), 64'h0);
      end
      finish_test("reset", err_mark);

      // Integrity, strobe mapping and framing on random traffic
      err_mark = errors;
      repeat (200) send_packet(1 + int'(next_rand() % MAX_LEN));
      wait_drained();
      finish_test("random traffic", err_mark);

      // MAC held off so the FIFO fills and tready drops
      err_mark = errors;
      low_mark = tready_low_cycles;
      stall_mac = 1'b1;
      fork
         repeat (3) send_packet(MAX_LEN);
         begin
            cycles = 0;
            while (tready) begin
               @(negedge clk);
               cycles++;
               if (cycles > BEAT_LIMIT) abort_on_timeout("tready to fall");
            end
            repeat (50) @(negedge clk);
            stall_mac = 1'b0;
         end
      join
      wait_drained();
      check_value("tready", 64'(tready), 64'h1);
      if (tready_low_cycles == low_mark) begin
         errors++;
         $display("tready never fell while the MAC was held off");
      end
      finish_test("back-pressure", err_mark);

      $display("Tests run 3, tests failed %0d, checks %0d, errors %0d",
               tests_failed, checks, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- test/tx_path_sva.sv
// Control checks on the transmit queue, attached with bind
// Level width follows the FIFO address width from the params header
`timescale 1ns/10ps
`default_nettype none
`include "tx_path_params.svh"

module tx_path_sva (
   input logic                     clk,
   input logic                     reset,
   input tx_path_pkg::tx_state_t   state,
   input logic [`TX_PKT_CNT_W-1:0] pkt_cnt,
   input logic                     tx_start,
   input logic [7:0]               tx_data_valid,
   input logic                     wr_en,
   input logic [`TX_FIFO_ADDR_W:0] fifo_level
);
   import tx_path_pkg::*;

   localparam logic [`TX_FIFO_ADDR_W:0] FULL_LEVEL = (`TX_FIFO_ADDR_W+1)'(1 << `TX_FIFO_ADDR_W);

   // Start only from IDLE, then the machine waits for the ack
   a_start_in_idle: assert property (@(posedge clk) disable iff (reset)
      tx_start |=> (state == WAIT_ACK) && ($past(state) == IDLE))
      else $error("tx_start outside IDLE or not followed by WAIT_ACK");

   // Every counted packet still has its beats in the FIFO
   a_cnt_in_fifo: assert property (@(posedge clk) disable iff (reset)
      fifo_level >= pkt_cnt) else $error("packet count exceeds FIFO level");

   a_start_pulse: assert property (@(posedge clk) disable iff (reset)
      tx_start |=> !tx_start) else $error("tx_start longer than one cycle");

   // Byte-valid only in SEND and always bytes 0..n
   a_valid_in_send: assert property (@(posedge clk) disable iff (reset)
      tx_data_valid != 8'h00 |->
         (state == SEND) && (((tx_data_valid + 8'h01) & tx_data_valid) == 8'h00))
      else $error("byte-valid outside SEND or not low-aligned");

   a_no_full_write: assert property (@(posedge clk) disable iff (reset)
      wr_en |-> fifo_level != FULL_LEVEL) else $error("FIFO write while full");

endmodule

bind tx_queue tx_path_sva u_sva (
   .clk           (clk),
   .reset         (reset),
   .state         (state),
   .pkt_cnt       (pkt_cnt),
   .tx_start      (tx_start),
   .tx_data_valid (tx_data_valid),
   .wr_en         (beat_accept),
   .fifo_level    (wr.level)
);

`default_nettype wire
